/* flist.f */
verilog/xgmii_rx_pkg.sv
verilog/rx_stream_if.sv
verilog/xgmii_lane_decoder.sv
verilog/rx_framer.sv
verilog/crc32_x32_variable.sv
verilog/fcs_checker.sv
verilog/xg_mac_rx.sv
test/tb_xg_mac_rx.sv

/* test/tb_xg_mac_rx.sv */
module tb_xg_mac_rx import xgmii_rx_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// 8 good, bad FCS, error, bad preamble plus its good follower, back to back pair
	localparam int N_FRAMES = 14;
	localparam int N_GOOD = 11;
	localparam int WATCHDOG_CYCLES = N_FRAMES * 40 + 200;
	localparam xgmii_word_t IDLE_WORD = {4{XGMII_IDLE}};

	logic        xgmii_rx_clk;
	logic        rst_n;
	logic        xgmii_rx_valid;
	xgmii_ctl_t  xgmii_rx_ctl;
	xgmii_word_t xgmii_rx_data;
	logic        rx_start;
	logic        rx_data_valid;
	byte_count_t rx_bytes_valid;
	xgmii_word_t rx_data;
	logic        rx_commit;
	logic        rx_drop;

	// Tags that travel with each driven word
	byte_count_t tag_bytes;
	logic        tag_pre;
	logic        tag_good;
	logic        tag_bad;
	logic        tag_err;

	// Tags aligned to DUT outputs, counted in valid cycles
	byte_count_t bytes_q;
	logic        start_q;
	logic        err_q;
	logic [2:0]  good_pipe;
	logic [2:0]  bad_pipe;

	// Payload bytes still owed to the upper layer
	logic [7:0] sb_q[$];
	logic [7:0] want_b;
	logic [7:0] got_b;
	int         commit_count;
	integer     seed = 32'hc10696c6;

	xg_mac_rx dut0 (.*);

	initial begin
		xgmii_rx_clk = 1'b0;
		forever #5 xgmii_rx_clk = ~xgmii_rx_clk;
	end

	//////////////////////////////
	// Failure reporting

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("error: %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	// Byte-serial Ethernet CRC, LSB of each byte first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic fb;

		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ d[i];
			c = {1'b0, c[31:1]};
			if (fb) begin
				c = c ^ 32'hedb8_8320;
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// Word driver

	task automatic drive_word(input xgmii_ctl_t c, input xgmii_word_t d, input int nb,
		input bit pre, input bit good, input bit bad, input bit err);
		@(posedge xgmii_rx_clk);
		#1;
		// Now and then a dead clock, the DUT must freeze
		if (($random(seed) & 7) == 0) begin
			xgmii_rx_valid = 1'b0;
			@(posedge xgmii_rx_clk);
			#1;
		end
		xgmii_rx_valid = 1'b1;
		xgmii_rx_ctl   = c;
		xgmii_rx_data  = d;
		tag_bytes      = byte_count_t'(nb);
		tag_pre        = pre;
		tag_good       = good;
		tag_bad        = bad;
		tag_err        = err;
	endtask

	// Start word, preamble, payload, FCS, terminate; err_word < 0 means no error
	task automatic send_frame(input int len, input int n_idle, input bit bad_fcs,
		input bit bad_pre, input int err_word);
		logic [7:0]  bq[$];
		bit          cq[$];
		logic [31:0] crc;
		logic [7:0]  b;
		int          nb;
		int          term_w;
		bit          live;
		xgmii_word_t w;
		xgmii_ctl_t  c;

		crc = '1;
		for (int i = 0; i < len; i++) begin
			b = $random(seed);
			bq.push_back(b);
			cq.push_back(1'b0);
			crc = crc_byte(crc, b);
		end
		// FCS goes out low byte first
		crc = ~crc;
		for (int i = 0; i < 4; i++) begin
			b = crc[8*i +: 8];
			if (bad_fcs && (i == 0)) begin
				b = b ^ 8'h10;
			end
			bq.push_back(b);
			cq.push_back(1'b0);
		end
		bq.push_back(XGMII_TERMINATE);
		cq.push_back(1'b1);
		while ((bq.size() % 4) != 0) begin
			bq.push_back(XGMII_IDLE);
			cq.push_back(1'b1);
		end

		repeat (n_idle) drive_word(4'hf, IDLE_WORD, 0, 0, 0, 0, 0);
		drive_word(4'b1000, {XGMII_START, 24'h55_5555}, 0, 0, 0, 0, 0);
		drive_word(4'h0, bad_pre ? 32'h5555_5555 : PREAMBLE_SFD_WORD, 0, 1, 0, 0, 0);

		live   = !bad_pre;
		term_w = (len + 4) / 4;
		for (int k = 0; k < bq.size() / 4; k++) begin
			w  = {bq[4*k], bq[4*k+1], bq[4*k+2], bq[4*k+3]};
			c  = {cq[4*k], cq[4*k+1], cq[4*k+2], cq[4*k+3]};
			nb = len - 4 * k;
			nb = (nb > 4) ? 4 : ((nb < 0) ? 0 : nb);
			if (live && (k == err_word)) begin
				// Rest of the frame is dead to the framer
				live = 1'b0;
				drive_word(4'hf, {4{XGMII_ERROR}}, 0, 0, 0, 0, 1);
			end else begin
				if (!live) begin
					nb = 0;
				end
				for (int i = 0; i < nb; i++) begin
					sb_q.push_back(bq[4*k+i]);
				end
				drive_word(c, w, nb, 0, live && (k == term_w) && !bad_fcs,
					live && (k == term_w) && bad_fcs, 0);
			end
		end
	endtask

	//////////////////////////////
	// Expected timing model

	always @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			bytes_q   <= '0;
			start_q   <= 1'b0;
			err_q     <= 1'b0;
			good_pipe <= '0;
			bad_pipe  <= '0;
		end else if (xgmii_rx_valid) begin
			bytes_q   <= tag_bytes;
			start_q   <= tag_pre;
			err_q     <= tag_err;
			good_pipe <= {good_pipe[1:0], tag_good};
			bad_pipe  <= {bad_pipe[1:0], tag_bad};
		end
	end

	// Marked bytes, lane 3 first, against the payload
	always @(posedge xgmii_rx_clk) begin
		if (rst_n && xgmii_rx_valid && rx_data_valid) begin
			for (int b = 0; b < rx_bytes_valid; b++) begin
				if (sb_q.size() == 0) begin
					report_failure("data byte marked valid while no payload byte was due");
				end
				want_b = sb_q.pop_front();
				got_b  = rx_data[31-8*b -: 8];
				if (got_b != want_b) begin
					report_mismatch("rx_data", want_b, got_b);
				end
			end
		end
		if (rst_n && xgmii_rx_valid && rx_commit) begin
			commit_count++;
		end
	end

	a_start: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		xgmii_rx_valid |-> (rx_start == start_q))
		else report_mismatch("rx_start", $sampled(start_q), $sampled(rx_start));

	a_bytes: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		xgmii_rx_valid |-> (rx_bytes_valid == bytes_q))
		else report_mismatch("rx_bytes_valid", $sampled(bytes_q), $sampled(rx_bytes_valid));

	a_valid: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		xgmii_rx_valid |-> (rx_data_valid == (bytes_q != 0)))
		else report_mismatch("rx_data_valid", $sampled(bytes_q != 0), $sampled(rx_data_valid));

	// Combinational qualifier follows the input strobe
	a_quiet: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		!xgmii_rx_valid |-> !rx_data_valid)
		else report_mismatch("rx_data_valid", 32'h0, $sampled(rx_data_valid));

	a_commit: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		xgmii_rx_valid |-> (rx_commit == good_pipe[2]))
		else report_mismatch("rx_commit", $sampled(good_pipe[2]), $sampled(rx_commit));

	a_drop: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		xgmii_rx_valid |-> (rx_drop == (bad_pipe[2] | err_q)))
		else report_mismatch("rx_drop", $sampled(bad_pipe[2] | err_q), $sampled(rx_drop));

	//////////////////////////////
	// Test sequence

	initial begin
		rst_n          = 1'b0;
		xgmii_rx_valid = 1'b0;
		xgmii_rx_ctl   = 4'hf;
		xgmii_rx_data  = IDLE_WORD;
		tag_bytes      = '0;
		tag_pre        = 1'b0;
		tag_good       = 1'b0;
		tag_bad        = 1'b0;
		tag_err        = 1'b0;
		commit_count   = 0;
		repeat (3) @(posedge xgmii_rx_clk);
		#1;
		rst_n = 1'b1;

		// Quiet link
		repeat (20) drive_word(4'hf, IDLE_WORD, 0, 0, 0, 0, 0);
		// Terminate in each of the four lanes
		for (int i = 0; i < 4; i++) begin
			send_frame(60 + i, 3, 0, 0, -1);
		end
		repeat (4) send_frame(60 + (($random(seed) & 32'h7fff_ffff) % 41), 3, 0, 0, -1);
		send_frame(77, 3, 1, 0, -1);
		send_frame(80, 3, 0, 0, 5);
		send_frame(70, 3, 0, 1, -1);
		send_frame(65, 3, 0, 0, -1);
		// Back to back, one idle word apart
		send_frame(62, 3, 0, 0, -1);
		send_frame(91, 1, 0, 0, -1);
		repeat (8) drive_word(4'hf, IDLE_WORD, 0, 0, 0, 0, 0);
		@(posedge xgmii_rx_clk);

		if (sb_q.size() != 0) begin
			report_failure("payload bytes were sent that never came out marked valid");
		end else if (commit_count != N_GOOD) begin
			report_mismatch("commit count", N_GOOD, commit_count);
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	// Hang guard
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge xgmii_rx_clk);
		$display("STATUS: FAIL");
		$fatal(1, "timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
	end

endmodule

/* verilog/crc32_x32_variable.sv */
module crc32_x32_variable import xgmii_rx_pkg::*; (
	input  logic      xgmii_rx_clk,
	input  logic      rst_n,
	input  logic      xgmii_rx_valid,
	rx_stream_if.sink stream,
	output crc_t      crc_out
);

	// Stage 1 control
	logic start_q;
	logic valid_q;

	// Stage 1 payload
	byte_count_t len_q;
	xgmii_word_t data_q;

	// Stage 2 running CRC
	crc_t crc_state;

	// Byte-serial fold of up to four bytes, lane 3 first
	function automatic crc_t crc_fold(input crc_t crc_in, input xgmii_word_t din,
		input byte_count_t len);
		crc_t c;

		c = crc_in;
		for (int b = 0; b < 4; b++) begin
			if (b < len) begin
				c = c ^ {24'h0, din[31-8*b -: 8]};
				// Reflected form, LSB first
				for (int k = 0; k < 8; k++) begin
					c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
				end
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// Stage 1, input register

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			valid_q <= 1'b0;
		end else if (xgmii_rx_valid) begin
			start_q <= stream.start;
			valid_q <= stream.data_valid;
		end
	end

	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			data_q <= stream.data;
			len_q  <= stream.bytes_valid;
		end
	end

	//////////////////////////////
	// Stage 2, fold into state

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_state <= '1;
		end else if (xgmii_rx_valid) begin
			if (start_q) begin
				crc_state <= '1;
			end else if (valid_q) begin
				crc_state <= crc_fold(crc_state, data_q, len_q);
			end
		end
	end

	// Inverted, low byte goes out first on the wire
	assign crc_out = ~{crc_state[7:0], crc_state[15:8], crc_state[23:16], crc_state[31:24]};

	a_len_range: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		stream.bytes_valid <= 3'd4);

endmodule

/* verilog/fcs_checker.sv */
module fcs_checker import xgmii_rx_pkg::*; (
	input  logic      xgmii_rx_clk,
	input  logic      rst_n,
	input  logic      xgmii_rx_valid,
	rx_stream_if.sink stream,
	input  crc_t      fcs_expected,
	input  logic      frame_end,
	input  logic      any_end,
	input  logic      any_error,
	input  crc_t      crc_out,
	output logic      rx_commit,
	output logic      rx_drop
);

	// One flag per delay stage, oldest at the top
	logic [CRC_LATENCY-1:0] pending;
	crc_t fcs_dly [CRC_LATENCY];

	// Between start pulse and terminate
	logic in_frame;
	logic error_hit;

	assign error_hit = any_error && in_frame;

	// Received FCS waits for the CRC pipeline
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			fcs_dly[0] <= fcs_expected;
			for (int i = 1; i < CRC_LATENCY; i++) begin
				fcs_dly[i] <= fcs_dly[i-1];
			end
		end
	end

	//////////////////////////////
	// Commit or drop

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= '0;
			in_frame  <= 1'b0;
			rx_commit <= 1'b0;
			rx_drop   <= 1'b0;
		end else if (xgmii_rx_valid) begin
			pending   <= (pending << 1) | frame_end;
			rx_commit <= 1'b0;
			rx_drop   <= 1'b0;

			// CRC result lines up with the oldest stage
			if (pending[CRC_LATENCY-1]) begin
				if (fcs_dly[CRC_LATENCY-1] == crc_out) begin
					rx_commit <= 1'b1;
				end else begin
					rx_drop <= 1'b1;
				end
			end

			// Any terminate closes the frame, also after a bad preamble
			if (stream.start) begin
				in_frame <= 1'b1;
			end else if (any_end) begin
				in_frame <= 1'b0;
			end

			// error char kills the frame and anything still in flight
			if (error_hit) begin
				pending   <= '0;
				in_frame  <= 1'b0;
				rx_commit <= 1'b0;
				rx_drop   <= 1'b1;
			end
		end
	end

	a_one_verdict: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		!(rx_commit && rx_drop));

endmodule

/* verilog/rx_framer.sv */
module rx_framer import xgmii_rx_pkg::*; (
	input  logic        xgmii_rx_clk,
	input  logic        rst_n,
	input  logic        xgmii_rx_valid,
	input  xgmii_ctl_t  xgmii_rx_ctl,
	input  xgmii_word_t xgmii_rx_data,
	input  xgmii_ctl_t  lane_start,
	input  xgmii_ctl_t  lane_end,
	input  xgmii_ctl_t  lane_error,
	rx_stream_if.framer stream,
	output crc_t        fcs_expected,
	output logic        frame_end
);

	rx_state_t rx_state;

	// Set for one valid cycle after the preamble word
	logic last_was_preamble;

	// Second preamble word is all data and exactly 55 55 55 D5
	logic preamble_ok;

	assign preamble_ok = (xgmii_rx_ctl == '0) && (xgmii_rx_data == PREAMBLE_SFD_WORD);

	// Terminate seen while inside the body
	assign frame_end = (rx_state == RX_BODY) && (|lane_end);

	//////////////////////////////
	// Held word

	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			stream.data <= xgmii_rx_data;
		end
	end

	//////////////////////////////
	// Byte marking and FCS splice

	// The held word is marked while the next word arrives, so the
	// terminate position in the current word tells how much of the
	// held word is data and where the FCS starts
	always_comb begin
		stream.bytes_valid = '0;
		stream.data_valid  = 1'b0;
		fcs_expected       = '0;

		if (xgmii_rx_valid && (rx_state == RX_BODY)) begin
			if (lane_end[3]) begin
				// Whole held word is FCS
				fcs_expected = stream.data;
			end else if (lane_end[2]) begin
				stream.bytes_valid = 3'd1;
				stream.data_valid  = 1'b1;
				fcs_expected       = {stream.data[23:0], xgmii_rx_data[31:24]};
			end else if (lane_end[1]) begin
				stream.bytes_valid = 3'd2;
				stream.data_valid  = 1'b1;
				fcs_expected       = {stream.data[15:0], xgmii_rx_data[31:16]};
			end else if (lane_end[0]) begin
				stream.bytes_valid = 3'd3;
				stream.data_valid  = 1'b1;
				fcs_expected       = {stream.data[7:0], xgmii_rx_data[31:8]};
			end else if (!last_was_preamble) begin
				// Full body word when no terminate is in sight
				stream.bytes_valid = 3'd4;
				stream.data_valid  = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Frame FSM

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state          <= RX_IDLE;
			last_was_preamble <= 1'b0;
			stream.start      <= 1'b0;
		end else if (xgmii_rx_valid) begin
			stream.start      <= 1'b0;
			last_was_preamble <= 1'b0;

			case (rx_state)
				// Start character is only legal in lane 3
				RX_IDLE: begin
					if (lane_start[3]) begin
						rx_state <= RX_PREAMBLE;
					end
				end
				// Exactly one preamble word and start pulses either way
				RX_PREAMBLE: begin
					stream.start      <= 1'b1;
					last_was_preamble <= 1'b1;
					rx_state          <= preamble_ok ? RX_BODY : RX_IDLE;
				end
				// Frame can end in any lane
				RX_BODY: begin
					if (|lane_end) begin
						rx_state <= RX_IDLE;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase

			// Error inside a frame wins over everything else
			if ((|lane_error) && (rx_state != RX_IDLE)) begin
				rx_state <= RX_IDLE;
			end
		end
	end

	// Word behind the preamble is never marked as data
	a_no_preamble_data: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		stream.data_valid |-> !last_was_preamble);

	// A frame only opens behind the exact SFD word
	a_body_after_sfd: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		(stream.start && (rx_state == RX_BODY)) |-> (stream.data == PREAMBLE_SFD_WORD));

endmodule

/* verilog/rx_stream_if.sv */
interface rx_stream_if import xgmii_rx_pkg::*; ();

	// One-cycle pulse ahead of the first data word, restarts the CRC
	logic start;

	// Word held from the previous valid input cycle
	xgmii_word_t data;

	// Number of leading bytes of data that belong to the frame
	byte_count_t bytes_valid;

	// Data word qualifier
	logic data_valid;

	// Framer side drives everything
	modport framer (output start, data, bytes_valid, data_valid);

	// CRC engine and FCS checker only listen
	modport sink (input start, data, bytes_valid, data_valid);

endinterface

/* verilog/xg_mac_rx.sv */
module xg_mac_rx import xgmii_rx_pkg::*; (
	input  logic        xgmii_rx_clk,
	input  logic        rst_n,
	input  logic        xgmii_rx_valid,
	input  xgmii_ctl_t  xgmii_rx_ctl,
	input  xgmii_word_t xgmii_rx_data,
	output logic        rx_start,
	output logic        rx_data_valid,
	output byte_count_t rx_bytes_valid,
	output xgmii_word_t rx_data,
	output logic        rx_commit,
	output logic        rx_drop
);

	// Decoded lane masks
	xgmii_ctl_t lane_start;
	xgmii_ctl_t lane_end;
	xgmii_ctl_t lane_error;
	logic any_end;
	logic any_error;

	// Framer to checker
	crc_t fcs_expected;
	logic frame_end;

	// CRC result
	crc_t crc_out;

	// Framed word stream
	rx_stream_if stream ();

	//////////////////////////////
	// Receive path

	xgmii_lane_decoder u_decoder (
		.xgmii_rx_ctl (xgmii_rx_ctl),
		.xgmii_rx_data(xgmii_rx_data),
		.lane_start   (lane_start),
		.lane_end     (lane_end),
		.lane_error   (lane_error),
		.any_end      (any_end),
		.any_error    (any_error)
	);

	rx_framer u_framer (
		.xgmii_rx_clk  (xgmii_rx_clk),
		.rst_n         (rst_n),
		.xgmii_rx_valid(xgmii_rx_valid),
		.xgmii_rx_ctl  (xgmii_rx_ctl),
		.xgmii_rx_data (xgmii_rx_data),
		.lane_start    (lane_start),
		.lane_end      (lane_end),
		.lane_error    (lane_error),
		.stream        (stream.framer),
		.fcs_expected  (fcs_expected),
		.frame_end     (frame_end)
	);

	crc32_x32_variable u_crc (
		.xgmii_rx_clk  (xgmii_rx_clk),
		.rst_n         (rst_n),
		.xgmii_rx_valid(xgmii_rx_valid),
		.stream        (stream.sink),
		.crc_out       (crc_out)
	);

	fcs_checker u_checker (
		.xgmii_rx_clk  (xgmii_rx_clk),
		.rst_n         (rst_n),
		.xgmii_rx_valid(xgmii_rx_valid),
		.stream        (stream.sink),
		.fcs_expected  (fcs_expected),
		.frame_end     (frame_end),
		.any_end       (any_end),
		.any_error     (any_error),
		.crc_out       (crc_out),
		.rx_commit     (rx_commit),
		.rx_drop       (rx_drop)
	);

	// Upper layer sees the stream as plain ports
	assign rx_start       = stream.start;
	assign rx_data_valid  = stream.data_valid;
	assign rx_bytes_valid = stream.bytes_valid;
	assign rx_data        = stream.data;

endmodule

/* verilog/xgmii_lane_decoder.sv */
module xgmii_lane_decoder import xgmii_rx_pkg::*; (
	input  xgmii_ctl_t  xgmii_rx_ctl,
	input  xgmii_word_t xgmii_rx_data,
	output xgmii_ctl_t  lane_start,
	output xgmii_ctl_t  lane_end,
	output xgmii_ctl_t  lane_error,
	output logic        any_end,
	output logic        any_error
);

	//////////////////////////////
	// Per-lane character match

	for (genvar i = 0; i < 4; i++) begin : g_lane
		logic [7:0] lane_byte;

		// Lane i lives in bits 8*i+7 : 8*i
		assign lane_byte = xgmii_rx_data[8*i +: 8];

		// A code only counts when the lane is flagged as control
		assign lane_start[i] = xgmii_rx_ctl[i] && (lane_byte == XGMII_START);
		assign lane_end[i]   = xgmii_rx_ctl[i] && (lane_byte == XGMII_TERMINATE);
		assign lane_error[i] = xgmii_rx_ctl[i] && (lane_byte == XGMII_ERROR);
	end

	//////////////////////////////
	// Word-level flags

	// Terminate anywhere in the word
	assign any_end = |lane_end;

	// Error anywhere in the word
	assign any_error = |lane_error;

endmodule

/* verilog/xgmii_rx_pkg.sv */
package xgmii_rx_pkg;

	//////////////////////////////
	// Widths that carry a meaning

	// One XGMII word, lane 3 in bits 31:24 is first on the wire
	typedef logic [31:0] xgmii_word_t;

	// Per-lane control flags, lane 3 on top
	typedef logic [3:0] xgmii_ctl_t;

	// Valid bytes in a word, 0 to 4
	typedef logic [2:0] byte_count_t;

	// CRC value or received FCS, first FCS byte in bits 31:24
	typedef logic [31:0] crc_t;

	//////////////////////////////
	// XGMII control characters

	localparam logic [7:0] XGMII_START     = 8'hfb;
	localparam logic [7:0] XGMII_TERMINATE = 8'hfd;
	localparam logic [7:0] XGMII_ERROR     = 8'hfe;
	localparam logic [7:0] XGMII_IDLE      = 8'h07;

	// Rest of preamble plus SFD, the only legal word after the start word
	localparam xgmii_word_t PREAMBLE_SFD_WORD = 32'h5555_55d5;

	// Reflected Ethernet polynomial
	localparam crc_t CRC_POLY = 32'hedb8_8320;

	// Valid cycles from a word entering the CRC engine to its result
	localparam int CRC_LATENCY = 2;

	// Receive framer states
	typedef enum logic [1:0] {
		RX_IDLE     = 2'd0,
		RX_PREAMBLE = 2'd1,
		RX_BODY     = 2'd2
	} rx_state_t;

endpackage
